//--- verilog/cart_pkg.sv
package cart_pkg;

	// Download stream widths
	localparam int addr_w = 25;
	localparam int data_w = 16;
	localparam int img_size_w = 64;

	// Index value reserved for cheat files
	localparam logic [7:0] code_index = 8'hFF;

	// Word addresses of the serial number in the cartridge header
	localparam logic [addr_w-1:0] hdr_serial_first = 25'h182;
	localparam logic [addr_w-1:0] hdr_serial_mid [3] = '{25'h184, 25'h186, 25'h188};
	localparam logic [addr_w-1:0] hdr_serial_last = 25'h18A;

	// Backup RAM image size in sectors
	localparam int bk_sectors = 128;
	localparam int sd_lba_w = 32;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic ttn2;
	} quirk_t;

	// Eight ASCII characters with the first one in the top byte
	typedef logic [63:0] serial_t;

	typedef enum logic [2:0] {
		q_sram,
		q_eeprom,
		q_fifo,
		q_noram,
		q_pier,
		q_ttn2
	} quirk_sel_t;

	typedef struct packed {
		serial_t    serial;
		quirk_sel_t sel;
	} serial_entry_t;

	////////////////////////////////////////////////////////////////////////////
	// Known cartridges needing special handling
	////////////////////////////////////////////////////////////////////////////
	localparam serial_entry_t serial_table [19] = '{
		'{"T-081276", q_sram},
		'{"T-81406 ", q_sram},
		'{"T-081586", q_sram},
		'{"T-81576 ", q_sram},
		'{"T-81476 ", q_sram},
		'{"MK-1215 ", q_eeprom},
		'{"G-4060  ", q_eeprom},
		'{"00001211", q_eeprom},
		'{"MK-1228 ", q_eeprom},
		'{"G-5538  ", q_eeprom},
		'{"00004076", q_eeprom},
		'{"T-12046 ", q_eeprom},
		'{"T-12053 ", q_eeprom},
		'{"G-4524  ", q_eeprom},
		'{"T-113016", q_noram},
		'{"T-89016 ", q_fifo},
		'{"T-574023", q_pier},
		'{"T-574013", q_pier},
		'{"TITAN002", q_ttn2}
	};

	// Cheat record with fields in big endian order as they arrive
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	function automatic logic is_code_download(input logic [7:0] index);
		return index == code_index;
	endfunction

endpackage

//--- verilog/download_if.sv
`timescale 1ns/1ps

interface download_if;
	import cart_pkg::*;

	logic              active;
	logic [7:0]        index;
	logic              wr;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] data;

	modport src (
		output active,
		output index,
		output wr,
		output addr,
		output data
	);

	modport sink (
		input active,
		input index,
		input wr,
		input addr,
		input data
	);

endinterface

//--- verilog/rom_loader.sv
`timescale 1ns/1ps

module rom_loader (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	download_if.sink                      dl,
	input  logic                          rom_wrack,
	output logic                          ioctl_wait,
	output logic                          rom_wr,
	output logic [cart_pkg::addr_w-1:0]   rom_wraddr,
	output logic [cart_pkg::data_w-1:0]   rom_din,
	output logic [cart_pkg::addr_w-1:0]   rom_size
);
	import cart_pkg::*;

	logic cart_dl;
	logic cart_dl_q;
	logic dl_rise;
	logic dl_fall;

	assign cart_dl = dl.active & ~is_code_download(dl.index);
	assign dl_rise = ~cart_dl_q & cart_dl;
	assign dl_fall = cart_dl_q & ~cart_dl;

	// Write request toggles once per word and the host waits until ack matches
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (dl_fall) begin
				ioctl_wait <= 1'b0;
			end
			if (dl_rise) begin
				rom_wr <= 1'b0;
			end else if (cart_dl) begin
				if (dl.wr) begin
					ioctl_wait <= 1'b1;
					rom_wr     <= ~rom_wr;
				end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

	// Last address seen is the image size
	always_ff @(posedge clk_sys) begin
		if (dl_fall) begin
			rom_size <= dl.addr;
		end
	end

	assign rom_wraddr = cart_dl ? dl.addr : rom_size;

	// Host words are little endian but memory wants them swapped
	assign rom_din = {dl.data[7:0], dl.data[15:8]};

endmodule

//--- verilog/cart_quirks.sv
`timescale 1ns/1ps

module cart_quirks (
	input  logic             clk_sys,
	input  logic             rst_n,
	download_if.sink         dl,
	output cart_pkg::quirk_t quirks
);
	import cart_pkg::*;

	logic        cart_dl;
	logic        cart_dl_q;
	logic        hdr_wr;
	logic        at_mid;
	logic [55:0] cart_id;
	serial_t     serial;
	quirk_t      hit;

	assign cart_dl = dl.active & ~is_code_download(dl.index);
	assign hdr_wr  = cart_dl & dl.wr;
	assign at_mid  = dl.addr inside {hdr_serial_mid};

	// Last character comes from the low byte of the final word
	assign serial = {cart_id, dl.data[7:0]};

	////////////////////////////////////////////////////////////////////////////
	// Serial lookup
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		hit = '0;
		for (int i = 0; i < $size(serial_table); i++) begin
			if (serial == serial_table[i].serial) begin
				case (serial_table[i].sel)
					q_sram:   hit.sram   = 1'b1;
					q_eeprom: hit.eeprom = 1'b1;
					q_fifo:   hit.fifo   = 1'b1;
					q_noram:  hit.noram  = 1'b1;
					q_pier:   hit.pier   = 1'b1;
					q_ttn2:   hit.ttn2   = 1'b1;
					default:  hit        = hit;
				endcase
			end
		end
	end

	// Header bytes shift in so the first character ends up on top
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (dl.addr == hdr_serial_first) begin
				cart_id <= {cart_id[47:0], dl.data[15:8]};
			end else if (at_mid) begin
				cart_id <= {cart_id[39:0], dl.data[7:0], dl.data[15:8]};
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q <= 1'b0;
			quirks    <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (~cart_dl_q & cart_dl) begin
				quirks <= '0;
			end else if (hdr_wr && dl.addr == hdr_serial_last) begin
				quirks <= quirks | hit;
			end
		end
	end

endmodule

//--- verilog/cheat_loader.sv
`timescale 1ns/1ps

module cheat_loader (
	input  logic               clk_sys,
	input  logic               rst_n,
	download_if.sink           dl,
	output cart_pkg::gg_code_t gg_code,
	output logic               gg_valid,
	output logic               gg_reset
);
	import cart_pkg::*;

	logic code_wr;

	assign code_wr = dl.active & is_code_download(dl.index) & dl.wr;

	// First word of a new file flushes the cheat list
	assign gg_reset = code_wr && (dl.addr == '0);

	// Byte offset within the 16 byte record picks the half word
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:    gg_code.flags[15:0]    <= dl.data;
				4'd2:    gg_code.flags[31:16]   <= dl.data;
				4'd4:    gg_code.address[15:0]  <= dl.data;
				4'd6:    gg_code.address[31:16] <= dl.data;
				4'd8:    gg_code.compare[15:0]  <= dl.data;
				4'd10:   gg_code.compare[31:16] <= dl.data;
				4'd12:   gg_code.replace[15:0]  <= dl.data;
				4'd14:   gg_code.replace[31:16] <= dl.data;
				default: gg_code                <= gg_code;
			endcase
		end
	end

	// Record complete once the top replace word lands
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			gg_valid <= 1'b0;
		end else begin
			gg_valid <= code_wr && (dl.addr[3:0] == 4'd14);
		end
	end

endmodule

//--- verilog/backup_sequencer.sv
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                              clk_sys,
	input  logic                              rst_n,
	input  logic                              dl_active,
	input  logic                              cart_active,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [cart_pkg::img_size_w-1:0]   img_size,
	input  logic                              bk_load,
	input  logic                              bk_save,
	input  logic                              autosave,
	input  logic                              osd_status,
	input  logic                              bram_change,
	input  logic                              sd_ack,
	output logic [cart_pkg::sd_lba_w-1:0]     sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              bk_ena,
	output logic                              sav_pending
);
	import cart_pkg::*;

	typedef enum logic {
		st_idle,
		st_busy
	} bk_state_t;

	bk_state_t state;
	logic      cart_dl;
	logic      cart_dl_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      save_req;
	logic      start;
	logic      start_load;
	logic      sector_done;
	logic      last_sector;

	assign cart_dl  = dl_active & cart_active;
	assign save_req = bk_save | (sav_pending & osd_status & autosave);

	// Manual load, manual or auto save, or reload after a fresh cartridge
	assign start_load = (~load_q & bk_load) | (cart_dl_q & ~cart_dl & (|img_size));
	assign start      = (state == st_idle) & bk_ena & (start_load | (~save_q & save_req));

	assign sector_done = ack_q & ~sd_ack;
	assign last_sector = sd_lba == sd_lba_w'(bk_sectors - 1);
	assign bk_busy     = state == st_busy;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state       <= st_idle;
			cart_dl_q   <= 1'b0;
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			ack_q       <= 1'b0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			bk_loading  <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			load_q    <= bk_load;
			save_q    <= save_req;
			ack_q     <= sd_ack;

			// Save image gets mounted before the download finishes
			if (~cart_dl_q & cart_dl) begin
				bk_ena <= 1'b0;
			end
			if (cart_dl & img_mounted & ~img_readonly) begin
				bk_ena <= 1'b1;
			end

			if (bram_change & ~osd_status) begin
				sav_pending <= 1'b1;
			end else if (bk_busy) begin
				sav_pending <= 1'b0;
			end

			// Device has taken the request
			if (~ack_q & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (start) begin
						state      <= st_busy;
						bk_loading <= start_load;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				st_busy: begin
					if (sector_done) begin
						if (last_sector) begin
							state      <= st_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Sector address walks up by one per finished sector
	always_ff @(posedge clk_sys) begin
		if (start) begin
			sd_lba <= '0;
		end else if (bk_busy && sector_done && !last_sector) begin
			sd_lba <= sd_lba + 1'd1;
		end
	end

endmodule

//--- verilog/cart_control_top.sv
`timescale 1ns/1ps

module cart_control_top (
	input  logic                              clk_sys,
	input  logic                              rst_n,
	input  logic                              dl_active,
	input  logic [7:0]                        dl_index,
	input  logic                              dl_wr,
	input  logic [cart_pkg::addr_w-1:0]       dl_addr,
	input  logic [cart_pkg::data_w-1:0]       dl_data,
	input  logic                              rom_wrack,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [cart_pkg::img_size_w-1:0]   img_size,
	input  logic                              sd_ack,
	input  logic                              bk_load,
	input  logic                              bk_save,
	input  logic                              autosave,
	input  logic                              osd_status,
	input  logic                              bram_change,
	output logic                              ioctl_wait,
	output logic                              rom_wr,
	output logic [cart_pkg::addr_w-1:0]       rom_wraddr,
	output logic [cart_pkg::data_w-1:0]       rom_din,
	output logic [cart_pkg::addr_w-1:0]       rom_size,
	output cart_pkg::quirk_t                  quirks,
	output cart_pkg::gg_code_t                gg_code,
	output logic                              gg_valid,
	output logic                              gg_reset,
	output logic [cart_pkg::sd_lba_w-1:0]     sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              bk_ena,
	output logic                              sav_pending
);
	import cart_pkg::*;

	logic cart_active;

	download_if dl_bus ();

	// Host stream is broadcast to all three consumers
	assign dl_bus.active = dl_active;
	assign dl_bus.index  = dl_index;
	assign dl_bus.wr     = dl_wr;
	assign dl_bus.addr   = dl_addr;
	assign dl_bus.data   = dl_data;

	assign cart_active = ~is_code_download(dl_index);

	rom_loader rom_loader_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl_bus.sink),
		.rom_wrack  (rom_wrack),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_wraddr (rom_wraddr),
		.rom_din    (rom_din),
		.rom_size   (rom_size)
	);

	cart_quirks cart_quirks_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dl      (dl_bus.sink),
		.quirks  (quirks)
	);

	cheat_loader cheat_loader_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl       (dl_bus.sink),
		.gg_code  (gg_code),
		.gg_valid (gg_valid),
		.gg_reset (gg_reset)
	);

	backup_sequencer backup_sequencer_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.cart_active  (cart_active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.bram_change  (bram_change),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_ena       (bk_ena),
		.sav_pending  (sav_pending)
	);

endmodule

//--- tests/cart_tasks.svh
// Six words with distinct byte lanes so a missing swap shows
task automatic load_rom_image();
	logic [data_w-1:0] data;
	start_cart();
	for (int i = 0; i < 6; i++) begin
		data = data_w'(16'h1234 + 16'h1111 * i);
		cart_word(addr_w'(16'h0040 + 2 * i), data);
	end
	end_cart(addr_w'(16'h004A));
endtask

task automatic detect_quirks();
	quirk_t exp;
	exp      = '0;
	exp.fifo = 1'b1;
	download_header("T-89016 ");
	check_eq("quirks", quirks, exp);
	exp        = '0;
	exp.eeprom = 1'b1;
	download_header("G-4060  ");
	check_eq("quirks", quirks, exp);
	download_header("X-12345 ");
	check_eq("quirks", quirks, '0);
endtask

task automatic load_cheat_record();
	gg_code_t          exp;
	logic [data_w-1:0] words [8];
	for (int i = 0; i < 8; i++) begin
		words[i] = data_w'(16'hA0B0 + 16'h0101 * i);
	end
	// Low half word arrives first in each field
	exp.flags   = {words[1], words[0]};
	exp.address = {words[3], words[2]};
	exp.compare = {words[5], words[4]};
	exp.replace = {words[7], words[6]};
	dl_index    = code_index;
	dl_active   = 1'b1;
	tick();
	for (int i = 0; i < 8; i++) begin
		code_word(addr_w'(2 * i), words[i]);
	end
	tick();
	check_eq("gg_valid", gg_valid, 1'b0);
	check_eq("gg_code", gg_code, exp);
	dl_active = 1'b0;
	dl_index  = 8'h00;
	tick();
endtask

task automatic autoload_backup();
	clear_device_counts();
	img_mounted  = 1'b1;
	img_readonly = 1'b0;
	img_size     = 64'h2_0000;
	start_cart();
	cart_word(addr_w'(0), 16'h4E45);
	cart_word(addr_w'(2), 16'h4741);
	check_eq("bk_ena", bk_ena, 1'b1);
	end_cart(addr_w'(2));
	check_eq("bk_busy", bk_busy, 1'b1);
	check_eq("bk_loading", bk_loading, 1'b1);
	wait_idle();
	check_eq("bk_loading", bk_loading, 1'b0);
	check_eq("sd reads", dev_rd_count, bk_sectors);
	check_eq("sd writes", dev_wr_count, 0);
endtask

task automatic autosave_backup();
	clear_device_counts();
	bram_change = 1'b1;
	tick();
	bram_change = 1'b0;
	check_eq("sav_pending", sav_pending, 1'b1);
	// Menu opening with autosave on kicks off the save
	autosave   = 1'b1;
	osd_status = 1'b1;
	tick();
	check_eq("bk_busy", bk_busy, 1'b1);
	check_eq("bk_loading", bk_loading, 1'b0);
	wait_idle();
	check_eq("sd writes", dev_wr_count, bk_sectors);
	check_eq("sd reads", dev_rd_count, 0);
	check_eq("sav_pending", sav_pending, 1'b0);
	osd_status = 1'b0;
	autosave   = 1'b0;
	tick();
endtask

task automatic readonly_image();
	clear_device_counts();
	img_readonly = 1'b1;
	start_cart();
	cart_word(addr_w'(0), 16'h5345);
	check_eq("bk_ena", bk_ena, 1'b0);
	end_cart(addr_w'(0));
	check_eq("bk_ena", bk_ena, 1'b0);
	check_eq("bk_busy", bk_busy, 1'b0);
	bk_load = 1'b1;
	tick();
	bk_load = 1'b0;
	repeat (50) begin
		tick();
		check_eq("sd_rd", sd_rd, 1'b0);
	end
	check_eq("sd reads", dev_rd_count, 0);
endtask

//--- tests/cart_control_tb.sv
`timescale 1ns/1ps

module cart_control_tb;
	import cart_pkg::*;

	localparam int max_cycles = 20000;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  dl_active;
	logic [7:0]            dl_index;
	logic                  dl_wr;
	logic [addr_w-1:0]     dl_addr;
	logic [data_w-1:0]     dl_data;
	logic                  rom_wrack;
	logic                  img_mounted;
	logic                  img_readonly;
	logic [img_size_w-1:0] img_size;
	logic                  sd_ack;
	logic                  bk_load;
	logic                  bk_save;
	logic                  autosave;
	logic                  osd_status;
	logic                  bram_change;
	logic                  ioctl_wait;
	logic                  rom_wr;
	logic [addr_w-1:0]     rom_wraddr;
	logic [data_w-1:0]     rom_din;
	logic [addr_w-1:0]     rom_size;
	quirk_t                quirks;
	gg_code_t              gg_code;
	logic                  gg_valid;
	logic                  gg_reset;
	logic [sd_lba_w-1:0]   sd_lba;
	logic                  sd_rd;
	logic                  sd_wr;
	logic                  bk_busy;
	logic                  bk_loading;
	logic                  bk_ena;
	logic                  sav_pending;

	integer seed = 45;
	int     cycle_count;
	int     dev_rd_count;
	int     dev_wr_count;
	int     dev_next_lba;
	logic   exp_rom_wr;

	cart_control_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic check_eq(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%0h expected 0x%0h", name, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory and block device models answer 2 ns after the edge
	////////////////////////////////////////////////////////////////////////////
	initial begin : rom_ack_model
		int delay;
		rom_wrack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (rst_n && (rom_wr !== rom_wrack)) begin
				delay = 1 + ($random(seed) & 3);
				repeat (delay) @(posedge clk_sys);
				#2 rom_wrack = rom_wr;
			end
		end
	end

	// Ack 2 cycles after the request and held for 3
	initial begin : block_device_model
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (rst_n && (sd_rd || sd_wr)) begin
				check_eq("sd_lba", sd_lba, dev_next_lba);
				check_eq("bk_loading", bk_loading, sd_rd);
				if (sd_rd) begin
					dev_rd_count++;
				end else begin
					dev_wr_count++;
				end
				dev_next_lba++;
				repeat (2) @(posedge clk_sys);
				#2 sd_ack = 1'b1;
				repeat (3) @(posedge clk_sys);
				#2 sd_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < max_cycles) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("ERROR: the tests did not finish within %0d clock cycles", max_cycles);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic clear_device_counts();
		dev_rd_count = 0;
		dev_wr_count = 0;
		dev_next_lba = 0;
	endtask

	// Opens a cartridge download and lets the ack catch up with the reset request
	task automatic start_cart();
		dl_index  = 8'h00;
		dl_active = 1'b1;
		tick();
		exp_rom_wr = 1'b0;
		check_eq("rom_wr", rom_wr, 1'b0);
		while (rom_wrack !== rom_wr) begin
			tick();
		end
	endtask

	task automatic cart_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		tick();
		dl_wr      = 1'b0;
		exp_rom_wr = ~exp_rom_wr;
		check_eq("rom_wr", rom_wr, exp_rom_wr);
		check_eq("ioctl_wait", ioctl_wait, 1'b1);
		check_eq("rom_din", rom_din, {data[7:0], data[15:8]});
		check_eq("rom_wraddr", rom_wraddr, addr);
		while (ioctl_wait) begin
			tick();
		end
		check_eq("rom_wrack", rom_wrack, rom_wr);
	endtask

	// Address is left on the bus so the size can be taken from it
	task automatic end_cart(input logic [addr_w-1:0] last_addr);
		dl_active = 1'b0;
		tick();
		check_eq("rom_size", rom_size, last_addr);
		check_eq("rom_wraddr", rom_wraddr, last_addr);
	endtask

	task automatic code_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		#2;
		check_eq("gg_reset", gg_reset, addr == '0);
		tick();
		dl_wr = 1'b0;
		check_eq("gg_valid", gg_valid, addr[3:0] == 4'd14);
	endtask

	task automatic wait_idle();
		while (bk_busy) begin
			tick();
		end
	endtask

	// Header word k of the serial with characters counted from the top byte
	function automatic logic [15:0] header_word(input serial_t serial, input int k);
		logic [7:0] c [8];
		for (int i = 0; i < 8; i++) begin
			c[i] = serial[63 - 8 * i -: 8];
		end
		if (k == 0) begin
			return {c[0], 8'h00};
		end else if (k == 4) begin
			return {8'h00, c[7]};
		end
		return {c[2 * k], c[2 * k - 1]};
	endfunction

	task automatic download_header(input serial_t serial);
		start_cart();
		check_eq("quirks", quirks, '0);
		for (int k = 0; k < 5; k++) begin
			cart_word(addr_w'(12'h182 + 2 * k), header_word(serial, k));
		end
		end_cart(addr_w'(12'h18A));
	endtask

	`include "cart_tasks.svh"

	initial begin
		rst_n        = 1'b0;
		dl_active    = 1'b0;
		dl_index     = 8'h00;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		osd_status   = 1'b0;
		bram_change  = 1'b0;
		exp_rom_wr   = 1'b0;
		clear_device_counts();
		repeat (4) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		// Everything visible comes out of reset low
		check_eq("rom_wr", rom_wr, 1'b0);
		check_eq("ioctl_wait", ioctl_wait, 1'b0);
		check_eq("quirks", quirks, '0);
		check_eq("gg_valid", gg_valid, 1'b0);
		check_eq("sd_rd", sd_rd, 1'b0);
		check_eq("sd_wr", sd_wr, 1'b0);
		check_eq("bk_busy", bk_busy, 1'b0);
		check_eq("bk_loading", bk_loading, 1'b0);
		check_eq("bk_ena", bk_ena, 1'b0);
		check_eq("sav_pending", sav_pending, 1'b0);

		load_rom_image();
		detect_quirks();
		load_cheat_record();
		autoload_backup();
		autosave_backup();
		readonly_image();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- cart_control_top.f
+incdir+tests
verilog/cart_pkg.sv
verilog/download_if.sv
verilog/rom_loader.sv
verilog/cart_quirks.sv
verilog/cheat_loader.sv
verilog/backup_sequencer.sv
verilog/cart_control_top.sv
tests/cart_control_tb.sv
